// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_uart_rx -f uart_rx.f
	out="$$(./obj_dir/Vtb_uart_rx)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== rx_byte_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface rx_byte_if;
  import uart_rx_pkg::*;

  logic     valid;
  logic     ready;
  rx_byte_t data;
  logic     frame_err;

  // deframer side, cannot stall
  modport src (
    output valid,
    output data,
    output frame_err,
    input  ready
  );

  modport dst (
    input  valid,
    input  data,
    input  frame_err,
    output ready
  );

endinterface

`default_nettype wire

// ==== rx_byte_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_byte_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  rx_byte_if.dst               byte_in,
  output logic                 rx_valid,
  input  logic                 rx_ready,
  output uart_rx_pkg::rx_byte_t rx_data,
  output logic                 rx_frame_err,
  output logic                 rx_overrun
);
  import uart_rx_pkg::*;

  rx_byte_t               data_mem [QUEUE_DEPTH];
  logic                   err_mem  [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   push;
  logic                   pop;
  logic                   drop;

  function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
    return (ptr == QUEUE_PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign byte_in.ready = (count != QUEUE_FULL);
  assign push = byte_in.valid & byte_in.ready;
  // a full queue loses the byte
  assign drop = byte_in.valid & ~byte_in.ready;

  assign rx_valid     = (count != '0);
  assign pop          = rx_valid & rx_ready;
  assign rx_data      = data_mem[rd_ptr];
  // low whenever nothing is queued
  assign rx_frame_err = rx_valid & err_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      data_mem[wr_ptr] <= byte_in.data;
      err_mem[wr_ptr]  <= byte_in.frame_err;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rx_overrun <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop)
      begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until the host pops
      if (drop)
      begin
        rx_overrun <= 1'b1;
      end
      else if (pop)
      begin
        rx_overrun <= 1'b0;
      end
    end
  end

  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= QUEUE_FULL
  );

  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_valid && !rx_ready) |=> ($stable(rx_data) && $stable(rx_frame_err))
  );

endmodule

`default_nettype wire

// ==== rx_deframer.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_deframer (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   line_sync,
  input  logic   samp_tick,
  rx_byte_if.src byte_out
);
  import uart_rx_pkg::*;

  rx_state_e               state;
  logic [SAMPLE_CNT_W-1:0] samp_cnt;
  logic [BIT_CNT_W-1:0]    bit_cnt;
  logic [1:0]              hist;
  logic [2:0]              window;
  logic                    vote;
  logic                    valid_q;
  logic                    ferr_q;
  rx_byte_t                shreg;
  logic                    take_bit;

  // last two samples plus the current one
  assign window = {hist, line_sync};
  assign vote = (window[2] & window[1]) | (window[2] & window[0]) | (window[1] & window[0]);

  assign take_bit = samp_tick && (state == ST_DATA) && (samp_cnt == FULL_BIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      samp_cnt <= '0;
      bit_cnt  <= '0;
      hist     <= {2{LINE_IDLE}};
      valid_q  <= 1'b0;
      ferr_q   <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      if (samp_tick)
      begin
        hist <= window[1:0];
        case (state)
          ST_IDLE:
          begin
            if (line_sync == LINE_START)
            begin
              state    <= ST_START;
              samp_cnt <= '0;
            end
          end
          ST_START:
          begin
            if (samp_cnt == HALF_BIT_LAST)
            begin
              samp_cnt <= '0;
              bit_cnt  <= '0;
              // glitch shorter than a quarter bit loses the vote
              state    <= (vote == LINE_START) ? ST_DATA : ST_IDLE;
            end
            else
            begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
          ST_DATA:
          begin
            if (samp_cnt == FULL_BIT_LAST)
            begin
              samp_cnt <= '0;
              bit_cnt  <= bit_cnt + 1'b1;
              if (bit_cnt == LAST_DATA_BIT)
              begin
                state <= ST_STOP;
              end
            end
            else
            begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
          ST_STOP:
          begin
            if (samp_cnt == FULL_BIT_LAST)
            begin
              samp_cnt <= '0;
              valid_q  <= 1'b1;
              ferr_q   <= (vote != LINE_IDLE);
              state    <= ST_IDLE;
            end
            else
            begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
          default:
          begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // lsb first, a bit at idle level is a one
  always_ff @(posedge clk)
  begin
    if (take_bit)
    begin
      shreg <= {(vote == LINE_IDLE), shreg[DATA_BITS-1:1]};
    end
  end

  assign byte_out.valid     = valid_q;
  assign byte_out.data      = shreg;
  assign byte_out.frame_err = ferr_q;

  a_bit_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    bit_cnt <= BIT_CNT_MAX
  );

  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_q |=> !valid_q
  );

endmodule

`default_nettype wire

// ==== rx_line_sampler.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_line_sampler (
  input  logic clk,
  input  logic rst_n,
  input  logic rx_line,
  output logic line_sync,
  output logic samp_tick
);
  import uart_rx_pkg::*;

  logic                  sync_meta;
  logic [PRESCALE_W-1:0] prescale_cnt;

  // two-flop synchronizer, parks at idle level in reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_meta <= LINE_IDLE;
      line_sync <= LINE_IDLE;
    end
    else
    begin
      sync_meta <= rx_line;
      line_sync <= sync_meta;
    end
  end

  // free-running prescaler, tick on the wrap
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prescale_cnt <= '0;
      samp_tick    <= 1'b0;
    end
    else
    begin
      if (prescale_cnt == PRESCALE_LAST)
      begin
        prescale_cnt <= '0;
      end
      else
      begin
        prescale_cnt <= prescale_cnt + 1'b1;
      end
      samp_tick <= (prescale_cnt == PRESCALE_LAST);
    end
  end

  // tick is an enable, never a level
  a_tick_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    samp_tick |=> !samp_tick
  );

endmodule

`default_nettype wire

// ==== tb_uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_rx;
  import uart_rx_pkg::*;

  logic     clk;
  logic     rst_n;
  logic     rx_line;
  logic     rx_valid;
  logic     rx_ready;
  rx_byte_t rx_data;
  logic     rx_frame_err;
  logic     rx_overrun;

  // scoreboard, front entry mirrored into plain variables
  rx_byte_t exp_data_q [$];
  logic     exp_ferr_q [$];
  rx_byte_t exp_data;
  logic     exp_ferr;
  int       exp_cnt;
  logic     hs_q;
  logic     quiet;
  int       fails;
  int       fails_at_start;
  int       tests_run;
  int       tests_failed;
  int       handshakes;

  uart_rx_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_line      (rx_line),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_data      (rx_data),
    .rx_frame_err (rx_frame_err),
    .rx_overrun   (rx_overrun)
  );

  always #20 clk = ~clk;

  a_quiet: assert property (
    @(posedge clk) quiet |-> (!rx_valid && !rx_frame_err && !rx_overrun)
  )
  else
  begin
    fails++;
    $display("[FAIL] %0t {rx_valid,rx_frame_err,rx_overrun} expected 000 got %b", $time,
             $sampled({rx_valid, rx_frame_err, rx_overrun}));
  end

  a_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_valid && rx_ready) |-> (exp_cnt != 0)
  )
  else
  begin
    fails++;
    $display("byte %h was taken at %0t but no frame was outstanding", $sampled(rx_data), $time);
  end

  a_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_valid && rx_ready && exp_cnt != 0) |-> (rx_data == exp_data)
  )
  else
  begin
    fails++;
    $display("[FAIL] %0t rx_data expected %h got %h", $time, $sampled(exp_data),
             $sampled(rx_data));
  end

  a_ferr: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_valid && rx_ready && exp_cnt != 0) |-> (rx_frame_err == exp_ferr)
  )
  else
  begin
    fails++;
    $display("[FAIL] %0t rx_frame_err expected %b got %b", $time, $sampled(exp_ferr),
             $sampled(rx_frame_err));
  end

  // any pop clears the sticky flag
  a_overrun_clear: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_valid && rx_ready) |=> !rx_overrun
  )
  else
  begin
    fails++;
    $display("[FAIL] %0t rx_overrun expected 0 got 1", $time);
  end

  task automatic refresh_front();
    exp_cnt = exp_data_q.size();
    if (exp_cnt != 0)
    begin
      exp_data = exp_data_q[0];
      exp_ferr = exp_ferr_q[0];
    end
  endtask

  always @(posedge clk)
  begin
    hs_q <= rst_n && rx_valid && rx_ready;
  end

  // retire the front entry half a clock after its handshake
  always @(negedge clk)
  begin
    if (hs_q && exp_data_q.size() != 0)
    begin
      exp_data = exp_data_q.pop_front();
      exp_ferr = exp_ferr_q.pop_front();
      handshakes++;
      refresh_front();
    end
  end

  task automatic idle_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drive_bit(input logic lvl);
    rx_line = lvl;
    repeat (CLKS_PER_SAMPLE * SAMPLES_PER_BIT) @(negedge clk);
  endtask

  // start high, data inverted lsb first, then the chosen stop level
  task automatic send_frame(input rx_byte_t b, input logic stop_lvl, input logic expect_it,
                            input logic expect_err);
    int i;
    if (expect_it)
    begin
      exp_data_q.push_back(b);
      exp_ferr_q.push_back(expect_err);
      refresh_front();
    end
    drive_bit(LINE_START);
    for (i = 0; i < DATA_BITS; i++)
    begin
      drive_bit(b[i] ? LINE_IDLE : LINE_START);
    end
    drive_bit(stop_lvl);
    rx_line = LINE_IDLE;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_cnt != 0 && n < 12 * CLKS_PER_SAMPLE * SAMPLES_PER_BIT)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_cnt != 0)
    begin
      $display("timeout at %0t: %0d sent byte(s) never came out", $time, exp_cnt);
      $display("** FAIL **");
      $finish;
    end
  endtask

  // random gap moves the frame against the prescaler phase
  task automatic send_single(input rx_byte_t b);
    idle_clocks(int'($urandom_range(64, 1)));
    send_frame(b, LINE_IDLE, 1'b1, 1'b0);
    wait_drained();
  endtask

  task automatic begin_test();
    fails_at_start = fails;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (fails == fails_at_start)
    begin
      $display("test %0d %s: ok", tests_run, name);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d error(s)", tests_run, name, fails - fails_at_start);
    end
  endtask

  initial
  begin
    rx_byte_t patterns [6];
    int i;
    patterns = '{8'b1010_1100, 8'b1001_0011, 8'b0100_1101, 8'h12, 8'hAA, 8'h55};
    void'($urandom(50));
    clk = 1'b0;
    rst_n = 1'b0;
    rx_line = LINE_IDLE;
    rx_ready = 1'b1;
    quiet = 1'b1;
    exp_cnt = 0;
    exp_data = '0;
    exp_ferr = 1'b0;
    fails = 0;
    tests_run = 0;
    tests_failed = 0;
    handshakes = 0;

    begin_test();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle_clocks(3 * CLKS_PER_SAMPLE * SAMPLES_PER_BIT);
    quiet = 1'b0;
    end_test("reset and idle line");

    begin_test();
    for (i = 0; i < 6; i++)
    begin
      send_single(patterns[i]);
    end
    for (i = 0; i < 8; i++)
    begin
      send_single(rx_byte_t'($urandom()));
    end
    end_test("single frames");

    begin_test();
    idle_clocks(int'($urandom_range(64, 1)));
    for (i = 0; i < 5; i++)
    begin
      send_frame(rx_byte_t'($urandom()), LINE_IDLE, 1'b1, 1'b0);
    end
    wait_drained();
    end_test("back-to-back frames");

    begin_test();
    // 12 clocks, under a quarter bit
    rx_line = LINE_START;
    idle_clocks(12);
    rx_line = LINE_IDLE;
    idle_clocks(3 * CLKS_PER_SAMPLE * SAMPLES_PER_BIT);
    send_single(8'hC3);
    end_test("short start pulse");

    begin_test();
    send_frame(8'h5A, LINE_START, 1'b1, 1'b1);
    idle_clocks(2 * CLKS_PER_SAMPLE * SAMPLES_PER_BIT);
    wait_drained();
    send_single(8'h3C);
    end_test("bad stop bit");

    begin_test();
    rx_ready = 1'b0;
    for (i = 0; i < QUEUE_DEPTH + 1; i++)
    begin
      send_frame(rx_byte_t'($urandom()), LINE_IDLE, i < QUEUE_DEPTH, 1'b0);
    end
    idle_clocks(CLKS_PER_SAMPLE * SAMPLES_PER_BIT);
    a_overrun_set: assert (rx_overrun)
    else
    begin
      fails++;
      $display("[FAIL] %0t rx_overrun expected 1 got %b", $time, rx_overrun);
    end
    rx_ready = 1'b1;
    wait_drained();
    idle_clocks(2 * CLKS_PER_SAMPLE * SAMPLES_PER_BIT);
    a_drained: assert (!rx_valid)
    else
    begin
      fails++;
      $display("[FAIL] %0t rx_valid expected 0 got %b", $time, rx_valid);
    end
    end_test("overrun with ready low");

    $display("tests %0d, failed %0d, bytes checked %0d, errors %0d", tests_run, tests_failed,
             handshakes, fails);
    if (fails == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_rx.f ====
uart_rx_pkg.sv
rx_byte_if.sv
rx_line_sampler.sv
rx_deframer.sv
rx_byte_queue.sv
uart_rx_top.sv
tb_uart_rx.sv

// ==== uart_rx_pkg.sv ====
`default_nettype none

package uart_rx_pkg;

  // line timing
  localparam int CLKS_PER_SAMPLE = 8;
  localparam int SAMPLES_PER_BIT = 8;
  localparam int DATA_BITS = 8;
  localparam int QUEUE_DEPTH = 4;

  // inverted line: idles low, start bit high
  localparam logic LINE_IDLE = 1'b0;
  localparam logic LINE_START = 1'b1;

  localparam int PRESCALE_W = $clog2(CLKS_PER_SAMPLE);
  localparam int SAMPLE_CNT_W = $clog2(SAMPLES_PER_BIT);
  localparam int BIT_CNT_W = $clog2(DATA_BITS + 1);
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(CLKS_PER_SAMPLE - 1);
  localparam logic [SAMPLE_CNT_W-1:0] HALF_BIT_LAST = SAMPLE_CNT_W'(SAMPLES_PER_BIT / 2 - 1);
  localparam logic [SAMPLE_CNT_W-1:0] FULL_BIT_LAST = SAMPLE_CNT_W'(SAMPLES_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0] LAST_DATA_BIT = BIT_CNT_W'(DATA_BITS - 1);
  localparam logic [BIT_CNT_W-1:0] BIT_CNT_MAX = BIT_CNT_W'(DATA_BITS);
  localparam logic [QUEUE_PTR_W-1:0] QUEUE_PTR_LAST = QUEUE_PTR_W'(QUEUE_DEPTH - 1);
  localparam logic [QUEUE_CNT_W-1:0] QUEUE_FULL = QUEUE_CNT_W'(QUEUE_DEPTH);

  typedef logic [DATA_BITS-1:0] rx_byte_t;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_START = 2'd1,
    ST_DATA  = 2'd2,
    ST_STOP  = 2'd3
  } rx_state_e;

endpackage

`default_nettype wire

// ==== uart_rx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx_line,
  output logic                  rx_valid,
  input  logic                  rx_ready,
  output uart_rx_pkg::rx_byte_t rx_data,
  output logic                  rx_frame_err,
  output logic                  rx_overrun
);

  logic line_sync;
  logic samp_tick;

  rx_byte_if byte_if ();

  rx_line_sampler u_sampler (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_line   (rx_line),
    .line_sync (line_sync),
    .samp_tick (samp_tick)
  );

  rx_deframer u_deframer (
    .clk       (clk),
    .rst_n     (rst_n),
    .line_sync (line_sync),
    .samp_tick (samp_tick),
    .byte_out  (byte_if.src)
  );

  rx_byte_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .byte_in      (byte_if.dst),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_data      (rx_data),
    .rx_frame_err (rx_frame_err),
    .rx_overrun   (rx_overrun)
  );

endmodule

`default_nettype wire
